/* qla_pkg.sv */
// shared widths, host address fields and the safety FSM states; referenced by scoped names
package qla_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    typedef logic [15:0]        cur_t;        // offset binary, mid-scale is zero current
    typedef logic [7:0]         reg_addr_t;   // {channel, device}
    typedef logic [31:0]        reg_data_t;
    typedef logic signed [23:0] enc_count_t;

    typedef logic [3:0] chan_field_t;         // upper address nibble
    typedef logic [3:0] dev_field_t;          // lower address nibble
    typedef logic [1:0] chan_idx_t;           // axis 1..4 mapped onto 0..3

    localparam int   num_chan = 4;
    localparam cur_t cur_mid  = 16'h8000;     // zero current

    // ------------------------------
    // device codes, low nibble of the address
    // ------------------------------
    localparam dev_field_t dev_status      = 4'd0;  // channel 0 only
    localparam dev_field_t dev_cmd         = 4'd0;
    localparam dev_field_t dev_fb          = 4'd1;
    localparam dev_field_t dev_enc_preload = 4'd4;  // write only
    localparam dev_field_t dev_enc_count   = 4'd5;

    typedef enum logic [1:0] {
        s_ok,
        s_pending,   // over limit, persistence running
        s_tripped    // latched until the host clears it
    } safety_state_t;

    function automatic chan_field_t addr_chan(reg_addr_t a);
        return a[7:4];
    endfunction

    function automatic dev_field_t addr_dev(reg_addr_t a);
        return a[3:0];
    endfunction

    // true for the motor axes, channel 0 is the board block
    function automatic logic axis_hit(reg_addr_t a);
        return (a[7:4] != 4'd0) && (a[7:4] <= 4'(num_chan));
    endfunction

    function automatic chan_idx_t axis_idx(reg_addr_t a);
        chan_field_t c;
        c = a[7:4] - 4'd1;
        return c[1:0];
    endfunction

endpackage

/* cmd_regs.sv */
// current command registers for axes 1-4; host writes device 0, words drive the DAC outputs
`timescale 1ns/1ns

module cmd_regs (
    input  logic                                       sysclk,
    input  logic                                       rst_n,
    input  logic                                       reg_wen,
    input  qla_pkg::reg_addr_t                         reg_addr,
    input  qla_pkg::reg_data_t                         reg_wdata,
    output qla_pkg::reg_data_t                         reg_rdata,
    output qla_pkg::cur_t [qla_pkg::num_chan-1:0]      cur_cmd
);

    // ------------------------------
    // address decode
    // ------------------------------
    logic                sel;    // device 0 on an axis channel
    qla_pkg::chan_idx_t  idx;

    assign sel = qla_pkg::axis_hit(reg_addr) &&
                 (qla_pkg::addr_dev(reg_addr) == qla_pkg::dev_cmd);
    assign idx = qla_pkg::axis_idx(reg_addr);

    // ------------------------------
    // command words
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_pkg::num_chan; i++) begin
                cur_cmd[i] <= qla_pkg::cur_mid;     // amplifiers idle at zero current
            end
        end else if (reg_wen && sel) begin
            cur_cmd[idx] <= reg_wdata[15:0];        // upper half ignored
        end
    end

    // read back, zero extended
    always_comb begin
        if (sel) begin
            reg_rdata = {16'h0000, cur_cmd[idx]};
        end else begin
            reg_rdata = '0;
        end
    end

    // commands feed the DACs and the safety checks, never leave them undefined
    a_cmd_known: assert property (@(posedge sysclk) disable iff (!rst_n)
        !$isunknown(cur_cmd))
        else $error("cur_cmd has unknown bits %h", cur_cmd);

endmodule

/* quad_encoder.sv */
// four quadrature decoders with synchronizers and 24-bit up/down counters, preloadable by host
`timescale 1ns/1ns

module quad_encoder (
    input  logic                          sysclk,
    input  logic                          rst_n,
    input  logic                          reg_wen,
    input  qla_pkg::reg_addr_t            reg_addr,
    input  qla_pkg::reg_data_t            reg_wdata,
    input  logic [qla_pkg::num_chan-1:0]  enc_a,
    input  logic [qla_pkg::num_chan-1:0]  enc_b,
    output qla_pkg::enc_count_t           reg_rdata
);

    // ------------------------------
    // input synchronizers
    // ------------------------------
    logic [qla_pkg::num_chan-1:0] a_meta, a_sync, a_prev;
    logic [qla_pkg::num_chan-1:0] b_meta, b_sync, b_prev;

    // free running, the chain settles while reset is held
    always_ff @(posedge sysclk) begin
        a_meta <= enc_a;
        a_sync <= a_meta;
        a_prev <= a_sync;    // last decoded state
        b_meta <= enc_b;
        b_sync <= b_meta;
        b_prev <= b_sync;
    end

    // ------------------------------
    // gray code step decode
    // ------------------------------
    logic [qla_pkg::num_chan-1:0] step;   // exactly one line toggled
    logic [qla_pkg::num_chan-1:0] fwd;    // 00 -> 01 -> 11 -> 10 direction

    assign step = (a_sync ^ a_prev) ^ (b_sync ^ b_prev);  // both toggled cancels out
    assign fwd  = a_prev ^ b_sync;

    // host access
    logic                          sel;
    qla_pkg::chan_idx_t            idx;
    logic [qla_pkg::num_chan-1:0]  load;

    assign sel = qla_pkg::axis_hit(reg_addr);
    assign idx = qla_pkg::axis_idx(reg_addr);

    always_comb begin
        load = '0;
        if (reg_wen && sel && (qla_pkg::addr_dev(reg_addr) == qla_pkg::dev_enc_preload)) begin
            load[idx] = 1'b1;
        end
    end

    // ------------------------------
    // position counters
    // ------------------------------
    qla_pkg::enc_count_t count [qla_pkg::num_chan];

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_pkg::num_chan; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < qla_pkg::num_chan; i++) begin
                if (load[i]) begin
                    count[i] <= reg_wdata[23:0];          // preload beats a step
                end else if (step[i]) begin
                    if (fwd[i]) begin
                        count[i] <= count[i] + 24'sd1;
                    end else begin
                        count[i] <= count[i] - 24'sd1;
                    end
                end
            end
        end
    end

    // preload device reads as 0
    always_comb begin
        if (sel && (qla_pkg::addr_dev(reg_addr) == qla_pkg::dev_enc_count)) begin
            reg_rdata = count[idx];
        end else begin
            reg_rdata = '0;
        end
    end

    // one step per clock at most, unless the host loaded a new value
    for (genvar i = 0; i < qla_pkg::num_chan; i++) begin : g_chk
        a_single_step: assert property (@(posedge sysclk) disable iff (!rst_n)
            ($past(rst_n) && !$past(load[i])) |->
                ((count[i] == $past(count[i])) ||
                 (count[i] == $past(count[i]) + 24'sd1) ||
                 (count[i] == $past(count[i]) - 24'sd1)))
            else $error("encoder %0d jumped from %0d to %0d", i + 1,
                        $past(count[i]), count[i]);
    end

endmodule

/* safety_check.sv */
// overcurrent detector for one axis; trips after a persistent over-limit and latches until cleared
`timescale 1ns/1ns

module safety_check #(
    parameter int trip_count    = 8,       // consecutive samples to trip
    parameter int safety_margin = 'h40     // added to twice the command magnitude
) (
    input  logic           sysclk,
    input  logic           rst_n,
    input  qla_pkg::cur_t  cur_in,         // feedback sample
    input  qla_pkg::cur_t  dac_in,         // commanded current
    input  logic           safety_clear,
    output logic           fault
);

    localparam int cnt_w = $clog2(trip_count + 1);

    // ------------------------------
    // magnitudes around mid-scale
    // ------------------------------
    logic [15:0] fb_mag, cmd_mag;
    logic [17:0] limit;
    logic        over;

    assign fb_mag  = (cur_in >= qla_pkg::cur_mid) ? cur_in - qla_pkg::cur_mid
                                                  : qla_pkg::cur_mid - cur_in;
    assign cmd_mag = (dac_in >= qla_pkg::cur_mid) ? dac_in - qla_pkg::cur_mid
                                                  : qla_pkg::cur_mid - dac_in;
    assign limit   = {1'b0, cmd_mag, 1'b0} + 18'(safety_margin);  // 2*|cmd| + margin
    assign over    = {2'b00, fb_mag} > limit;

    // ------------------------------
    // persistence FSM
    // ------------------------------
    qla_pkg::safety_state_t state, state_nxt;
    logic [cnt_w-1:0]       cnt, cnt_nxt;   // over-limit samples seen so far

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        if (safety_clear) begin             // host clear wins in any state
            state_nxt = qla_pkg::s_ok;
            cnt_nxt   = '0;
        end else begin
            case (state)
                qla_pkg::s_ok: begin
                    if (over && (trip_count <= 1)) begin
                        state_nxt = qla_pkg::s_tripped;
                    end else if (over) begin
                        state_nxt = qla_pkg::s_pending;
                        cnt_nxt   = cnt_w'(1);
                    end
                end
                qla_pkg::s_pending: begin
                    if (!over) begin                             // glitch, back to normal
                        state_nxt = qla_pkg::s_ok;
                        cnt_nxt   = '0;
                    end else if (cnt == cnt_w'(trip_count - 1)) begin
                        state_nxt = qla_pkg::s_tripped;          // this sample completes it
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + cnt_w'(1);
                    end
                end
                qla_pkg::s_tripped: state_nxt = qla_pkg::s_tripped;  // hold
                default:            state_nxt = qla_pkg::s_ok;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= qla_pkg::s_ok;
            cnt   <= '0;
            fault <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            fault <= (state_nxt == qla_pkg::s_tripped);
        end
    end

    a_fault_state: assert property (@(posedge sysclk) disable iff (!rst_n)
        fault == (state == qla_pkg::s_tripped))
        else $error("fault %b in state %s", fault, state.name());

endmodule

/* board_regs.sv */
// channel 0 board register: amplifier enable mask, fault status, board id and fault clear
`timescale 1ns/1ns

module board_regs #(
    parameter logic [3:0] board_id = 4'h1
) (
    input  logic                          sysclk,
    input  logic                          rst_n,
    input  logic                          reg_wen,
    input  qla_pkg::reg_addr_t            reg_addr,
    input  qla_pkg::reg_data_t            reg_wdata,
    input  logic [qla_pkg::num_chan-1:0]  fault,          // latched by the safety checks
    output qla_pkg::reg_data_t            reg_rdata,
    output logic                          safety_clear,   // one cycle pulse
    output logic [qla_pkg::num_chan-1:0]  amp_enable
);

    // ------------------------------
    // decode
    // ------------------------------
    logic sel;
    logic wr;

    assign sel = (qla_pkg::addr_chan(reg_addr) == 4'd0) &&
                 (qla_pkg::addr_dev(reg_addr) == qla_pkg::dev_status);
    assign wr  = reg_wen && sel;

    // ------------------------------
    // enable mask and clear
    // ------------------------------
    logic [qla_pkg::num_chan-1:0] enable_mask;   // host request, bit n is axis n+1

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            enable_mask  <= '0;
            safety_clear <= 1'b0;
            amp_enable   <= '0;
        end else begin
            if (wr) begin
                enable_mask <= reg_wdata[3:0];
            end
            safety_clear <= wr && reg_wdata[31];   // same write may also change the mask
            // a tripped axis stays off whatever the host asks
            amp_enable   <= enable_mask & ~fault;
        end
    end

    // ------------------------------
    // status word
    // ------------------------------
    always_comb begin
        if (sel) begin
            reg_rdata = {4'h0,          // 31:28
                         board_id,      // 27:24
                         12'h000,       // 23:12
                         amp_enable,    // 11:8
                         fault,         // 7:4
                         enable_mask};  // 3:0
        end else begin
            reg_rdata = '0;             // other channel 0 devices unused
        end
    end

    // fault from the checks must shut the amplifier on the very next edge
    a_amp_off: assert property (@(posedge sysclk) disable iff (!rst_n)
        $past(rst_n) |-> ((amp_enable & $past(fault)) == '0))
        else $error("amp_enable %b with fault %b", amp_enable, $past(fault));

endmodule

/* motor_ctrl_top.sv */
// motor channel controller top; ties the register blocks and safety checks to the host bus
`timescale 1ns/1ns

module motor_ctrl_top #(
    parameter int         trip_count    = 8,
    parameter int         safety_margin = 'h40,
    parameter logic [3:0] board_id      = 4'h1
) (
    input  logic                                   sysclk,
    input  logic                                   rst_n,
    // host register bus
    input  logic                                   reg_wen,
    input  qla_pkg::reg_addr_t                     reg_addr,
    input  qla_pkg::reg_data_t                     reg_wdata,
    output qla_pkg::reg_data_t                     reg_rdata,
    // converted ADC samples in, DAC words out
    input  qla_pkg::cur_t [qla_pkg::num_chan-1:0]  cur_fb,
    output qla_pkg::cur_t [qla_pkg::num_chan-1:0]  cur_cmd,
    // encoders and amplifiers
    input  logic [qla_pkg::num_chan-1:0]           enc_a,
    input  logic [qla_pkg::num_chan-1:0]           enc_b,
    output logic [qla_pkg::num_chan-1:0]           amp_enable
);

    qla_pkg::reg_data_t            rdata_cmd;
    qla_pkg::reg_data_t            rdata_chan0;
    qla_pkg::enc_count_t           rdata_enc;
    logic [qla_pkg::num_chan-1:0]  fault;
    logic                          safety_clear;

    // ------------------------------
    // register blocks
    // ------------------------------
    cmd_regs u_cmd (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (rdata_cmd),
        .cur_cmd   (cur_cmd)
    );

    quad_encoder u_enc (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_rdata (rdata_enc)
    );

    // channel 0, board level i/o
    board_regs #(
        .board_id (board_id)
    ) u_chan0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .reg_wen      (reg_wen),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .fault        (fault),
        .reg_rdata    (rdata_chan0),
        .safety_clear (safety_clear),
        .amp_enable   (amp_enable)
    );

    // ------------------------------
    // overcurrent checks, one per axis
    // ------------------------------
    for (genvar n = 0; n < qla_pkg::num_chan; n++) begin : g_safety
        safety_check #(
            .trip_count    (trip_count),
            .safety_margin (safety_margin)
        ) u_safe (
            .sysclk       (sysclk),
            .rst_n        (rst_n),
            .cur_in       (cur_fb[n]),
            .dac_in       (cur_cmd[n]),
            .safety_clear (safety_clear),   // shared clear for all axes
            .fault        (fault[n])
        );
    end

    // ------------------------------
    // read data routing
    // ------------------------------
    always_comb begin
        if (qla_pkg::addr_chan(reg_addr) == 4'd0) begin
            reg_rdata = rdata_chan0;              // special axis
        end else if (!qla_pkg::axis_hit(reg_addr)) begin
            reg_rdata = '0;                       // channels above 4
        end else begin
            case (qla_pkg::addr_dev(reg_addr))
                qla_pkg::dev_cmd:
                    reg_rdata = rdata_cmd;
                qla_pkg::dev_fb:
                    reg_rdata = {16'h0000, cur_fb[qla_pkg::axis_idx(reg_addr)]};
                qla_pkg::dev_enc_preload, qla_pkg::dev_enc_count:
                    reg_rdata = {{8{rdata_enc[23]}}, rdata_enc};   // sign extend
                default:
                    reg_rdata = '0;
            endcase
        end
    end

endmodule

/* tb_motor_ctrl.sv */
// self-checking random testbench and simulation top for motor_ctrl_top with a cycle model
`timescale 1ns/1ns

module tb_motor_ctrl;

    localparam int         trip_count    = 8;
    localparam int         safety_margin = 'h30;
    localparam logic [3:0] board_id      = 4'h9;
    localparam int n_cmd    = 40;      // command writes, each with two reads
    localparam int n_enc    = 50;      // encoder moves, 4 cycles hold and a read
    localparam int n_load   = 8;       // preloads
    localparam int n_hold   = 40;      // safety hold periods
    localparam int max_hold = 12;
    localparam int max_cycles = 20 + 3 * n_cmd + 5 * n_enc + 3 * n_load
                                + n_hold * (max_hold + 2) + 2 * trip_count + 40;

    logic                    sysclk, rst_n, reg_wen;
    qla_pkg::reg_addr_t      reg_addr;
    qla_pkg::reg_data_t      reg_wdata, reg_rdata;
    qla_pkg::cur_t [3:0]     cur_fb, cur_cmd;
    logic [3:0]              enc_a, enc_b, amp_enable;
    integer                  seed = 32'hb5e1;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic [15:0]        m_cmd [4];
    logic signed [23:0] m_count [4];
    logic [1:0]         m_pos [4];      // gray position of each encoder input
    logic [3:0]         m_mask, m_fault, m_amp;
    logic               m_clear;        // clear pulse seen by the checks at the next edge
    int                 m_run [4];      // consecutive over-limit samples

    motor_ctrl_top #(
        .trip_count    (trip_count),
        .safety_margin (safety_margin),
        .board_id      (board_id)
    ) dut0 (
        .sysclk (sysclk), .rst_n (rst_n), .reg_wen (reg_wen), .reg_addr (reg_addr),
        .reg_wdata (reg_wdata), .reg_rdata (reg_rdata), .cur_fb (cur_fb),
        .cur_cmd (cur_cmd), .enc_a (enc_a), .enc_b (enc_b), .amp_enable (amp_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [15:0] magnitude(logic [15:0] v);
        return (v >= 16'h8000) ? v - 16'h8000 : 16'h8000 - v;   // distance from zero current
    endfunction

    function automatic logic over_limit(logic [15:0] fb, logic [15:0] cmd);
        return int'(magnitude(fb)) > 2 * int'(magnitude(cmd)) + safety_margin;
    endfunction

    // feedback either just past the limit or anywhere inside it, random sign
    function automatic logic [15:0] fb_sample(logic [15:0] cmd, logic over);
        int lim;
        int mag;
        lim = 2 * int'(magnitude(cmd)) + safety_margin;
        mag = over ? lim + 1 + rand_below(512) : rand_below(lim + 1);
        return (rand_below(2) == 1) ? 16'(32'h8000 + mag) : 16'(32'h8000 - mag);
    endfunction

    function automatic logic [31:0] status_word();
        return {4'h0, board_id, 12'h000, m_amp, m_fault, m_mask};
    endfunction

    task automatic expect_eq(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // one clock edge, model first
    // ------------------------------
    task automatic step_clock();
        int ch;
        if (!rst_n) begin
            for (int n = 0; n < 4; n++) begin
                m_cmd[n]   = 16'h8000;
                m_count[n] = '0;
                m_run[n]   = 0;
            end
            {m_mask, m_fault, m_amp, m_clear} = '0;
        end else begin
            m_amp = m_mask & ~m_fault;                  // from the faults before this edge
            for (int n = 0; n < 4; n++) begin
                if (m_clear) begin
                    m_run[n]   = 0;
                    m_fault[n] = 1'b0;
                end else if (!m_fault[n]) begin         // a tripped axis holds
                    m_run[n] = over_limit(cur_fb[n], m_cmd[n]) ? m_run[n] + 1 : 0;
                    if (m_run[n] >= trip_count) begin
                        m_fault[n] = 1'b1;
                        m_run[n]   = 0;
                    end
                end
            end
            m_clear = 1'b0;
            ch = int'(reg_addr[7:4]);
            if (reg_wen && reg_addr == 8'h00) begin
                m_mask  = reg_wdata[3:0];
                m_clear = reg_wdata[31];
            end else if (reg_wen && ch >= 1 && ch <= 4 && reg_addr[3:0] == 4'd0) begin
                m_cmd[ch-1] = reg_wdata[15:0];
            end else if (reg_wen && ch >= 1 && ch <= 4 && reg_addr[3:0] == 4'd4) begin
                m_count[ch-1] = reg_wdata[23:0];
            end
        end
        @(posedge sysclk);
        #1;
        expect_eq("amp_enable", 32'(m_amp), 32'(amp_enable));
        for (int n = 0; n < 4; n++) begin
            expect_eq($sformatf("cur_cmd[%0d]", n), 32'(m_cmd[n]), 32'(cur_cmd[n]));
        end
    endtask

    task automatic write_reg(logic [7:0] addr, logic [31:0] data);
        reg_wen   = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        step_clock();
        reg_wen   = 1'b0;
    endtask

    // each read takes one clock cycle
    task automatic check_read(logic [7:0] addr, logic [31:0] exp);
        reg_wen  = 1'b0;
        reg_addr = addr;
        #1;                                             // combinational read settles
        expect_eq($sformatf("reg_rdata @%h", addr), exp, reg_rdata);
        step_clock();
    endtask

    task automatic check_count(int n);
        check_read({4'(n + 1), 4'd5}, {{8{m_count[n][23]}}, m_count[n]});
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        int          ch;
        int          len;
        logic [31:0] w;
        rst_n = 1'b0;
        reg_wen = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        enc_a = '0;
        enc_b = '0;
        for (int n = 0; n < 4; n++) begin
            cur_fb[n] = 16'h8000;
            m_pos[n]  = 2'd0;
        end
        repeat (10) step_clock();
        rst_n = 1'b1;
        step_clock();

        for (int n = 0; n < 4; n++) begin               // reset values
            check_read({4'(n + 1), 4'd0}, 32'h0000_8000);
            check_count(n);
        end
        check_read(8'h00, status_word());

        for (int i = 0; i < n_cmd; i++) begin           // command registers
            ch = rand_below(4);
            w  = $random(seed);
            write_reg({4'(ch + 1), 4'd0}, w);
            check_read({4'(ch + 1), 4'd0}, {16'h0000, w[15:0]});
            ch = rand_below(4);
            check_read({4'(ch + 1), 4'd0}, {16'h0000, m_cmd[ch]});
        end

        for (int i = 0; i < n_enc; i++) begin           // random moves, holds and double toggles
            for (int n = 0; n < 4; n++) begin
                case (rand_below(4))
                    1: begin
                        m_pos[n]   = m_pos[n] + 2'd1;
                        m_count[n] = m_count[n] + 24'sd1;
                    end
                    2: begin
                        m_pos[n]   = m_pos[n] - 2'd1;
                        m_count[n] = m_count[n] - 24'sd1;
                    end
                    3: m_pos[n] = m_pos[n] + 2'd2;       // both lines toggle so nothing counts
                    default: ;
                endcase
                {enc_a[n], enc_b[n]} = m_pos[n] ^ (m_pos[n] >> 1);
            end
            repeat (4) step_clock();                    // 3 cycles latency plus one
            check_count(rand_below(4));
        end
        for (int i = 0; i < n_load; i++) begin
            ch = rand_below(4);
            w  = $random(seed);
            write_reg({4'(ch + 1), 4'd4}, w);
            check_read({4'(ch + 1), 4'd5}, {{8{w[23]}}, w[23:0]});
            check_read({4'(ch + 1), 4'd4}, 32'h0);      // preload is write only
        end

        write_reg(8'h00, 32'h0000_000f);                // overcurrent latch
        for (int n = 0; n < 4; n++) begin
            write_reg({4'(n + 1), 4'd0}, 32'(16'h7c00 + 16'(rand_below(2048))));
        end
        for (int i = 0; i < n_hold; i++) begin
            for (int n = 0; n < 4; n++) begin
                cur_fb[n] = fb_sample(m_cmd[n], rand_below(2) == 1);
            end
            if (rand_below(4) == 0) begin
                write_reg(8'h00, 32'(rand_below(16)));
            end
            len = 1 + rand_below(max_hold);
            repeat (len) check_read(8'h00, status_word());
            ch = rand_below(4);
            check_read({4'(ch + 1), 4'd1}, {16'h0000, cur_fb[ch]});
        end

        for (int n = 0; n < 4; n++) begin               // clear and routing
            cur_fb[n] = fb_sample(m_cmd[n], 1'b1);
        end
        repeat (trip_count + 2) step_clock();
        check_read(8'h00, status_word());
        expect_eq("reg_rdata[7:4]", 32'hf, 32'(reg_rdata[7:4]));
        for (int n = 0; n < 4; n++) begin
            cur_fb[n] = 16'h8000;
        end
        write_reg(8'h00, 32'h8000_000f);
        step_clock();
        check_read(8'h00, status_word());
        expect_eq("reg_rdata[7:4]", 32'h0, 32'(reg_rdata[7:4]));
        expect_eq("reg_rdata[27:24]", 32'(board_id), 32'(reg_rdata[27:24]));
        check_read(8'h01, 32'h0);
        check_read(8'h50, 32'h0);
        for (int i = 0; i < 20; i++) begin
            len = 2 + rand_below(12);                   // devices 2, 3 and 6..15
            if (len >= 4) len = len + 2;
            check_read({4'(rand_below(16)), 4'(len)}, 32'h0);
        end

        $display("all tests passed");
        $finish;
    end

    initial begin
        #(max_cycles * 10 + 2000);
        $display("watchdog expired before the stimulus finished");
        $display("tests failed");
        $fatal(1);
    end

endmodule

/* compile.f */
qla_pkg.sv
cmd_regs.sv
quad_encoder.sv
safety_check.sv
board_regs.sv
motor_ctrl_top.sv
tb_motor_ctrl.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_motor_ctrl -f compile.f -o sim || exit 1
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: no pass message"; exit 1; }
echo "PASS"
